//--- cache_wb.f
verilog/cache_pkg.sv
verilog/cache_controller.sv
verilog/cache_store.sv
verilog/block_fill.sv
verilog/write_back_buffer.sv
verilog/memory_arbiter.sv
verilog/cache_top.sv
dv/main_store_model.sv
dv/cache_tb.sv

//--- dv/cache_tb.sv
// cache testbench
// runs a table of CPU reads and writes through the cache, predicts read
// data with a shadow word memory, and checks hit timing, stalls and the
// bytes written back on a dirty eviction
`timescale 1ns/10ps
`default_nettype none

module cache_tb;
    import cache_pkg::*;

    localparam int    N_ENTRIES    = 13;
    localparam int    QUIET_CYCLES = 6;
    localparam addr_t EVICT_BASE   = 16'h0050;  // tag 0, index 5
    localparam addr_t BOGUS_ADDR   = 16'h012A;
    localparam word_t BOGUS_DATA   = 16'hDEAD;

    typedef struct packed {
        logic       write;
        addr_t      addr;
        word_t      wdata;
        logic       exp_hit;
        logic       inject;      // extra pulse while stalled
        logic [7:0] exp_writes;  // total memory writes once the port is idle
    } stim_t;

    logic     clk;
    logic     reset;
    logic     cpu_req_valid;
    cpu_req_t cpu_req;
    logic     cpu_stall;
    logic     cpu_done;
    word_t    cpu_rdata;
    logic     mem_req;
    mem_req_t mem_cmd;
    byte_t    mem_rdata;
    logic     mem_ack;
    int       write_count;

    stim_t    stim   [N_ENTRIES];
    word_t    shadow [0:32767];  // indexed by word address
    int       errors;
    int       checks;

    cache_top uut
    (
        .clk, .reset, .cpu_req_valid, .cpu_req, .cpu_stall, .cpu_done, .cpu_rdata,
        .mem_req, .mem_cmd, .mem_rdata, .mem_ack
    );

    main_store_model u_mem
    (
        .clk, .reset, .mem_req, .mem_cmd, .mem_rdata, .mem_ack, .write_count
    );

    initial
    begin
        clk = 1'b0;
        forever
            #10 clk = ~clk;
    end

    ////////////////////////////////////////
    // reference model
    function automatic byte_t pattern_byte(input addr_t a);
        return a[7:0] ^ a[15:8];
    endfunction

    // low byte sits at the even address
    function automatic word_t pattern_word(input addr_t a);
        addr_t lo;
        lo = {a[15:1], 1'b0};
        return {pattern_byte(lo | 16'h0001), pattern_byte(lo)};
    endfunction

    task automatic check_that(input logic ok, input string msg);
        checks++;
        assert (ok)
        else
        begin
            errors++;
            $display("ERROR at %0t ns: %s", $time, msg);
        end
    endtask

    task automatic load_stim;
        //          write addr      wdata     hit   inj   writes
        stim[0]  = '{1'b0, 16'h0124, 16'h0000, 1'b0, 1'b0, 8'd0};
        stim[1]  = '{1'b0, 16'h012A, 16'h0000, 1'b1, 1'b0, 8'd0};  // same block
        stim[2]  = '{1'b1, 16'h012A, 16'hBEEF, 1'b1, 1'b0, 8'd0};
        stim[3]  = '{1'b0, 16'h012A, 16'h0000, 1'b1, 1'b1, 8'd0};
        stim[4]  = '{1'b0, 16'h012A, 16'h0000, 1'b1, 1'b0, 8'd0};
        stim[5]  = '{1'b1, 16'h0056, 16'h1234, 1'b0, 1'b0, 8'd0};  // write miss
        stim[6]  = '{1'b0, 16'h1050, 16'h0000, 1'b0, 1'b0, 8'd0};
        stim[7]  = '{1'b0, 16'h2058, 16'h0000, 1'b0, 1'b0, 8'd0};
        stim[8]  = '{1'b0, 16'h305E, 16'h0000, 1'b0, 1'b0, 8'd0};
        stim[9]  = '{1'b0, 16'h4052, 16'h0000, 1'b0, 1'b0, 8'd16}; // evicts tag 0
        stim[10] = '{1'b0, 16'h0056, 16'h0000, 1'b0, 1'b0, 8'd16}; // evicts tag 1
        stim[11] = '{1'b0, 16'h1050, 16'h0000, 1'b0, 1'b1, 8'd16};
        stim[12] = '{1'b0, 16'h012A, 16'h0000, 1'b1, 1'b0, 8'd16};
    endtask

    // memory port idle for a few cycles means the FIFO has drained
    task automatic wait_quiet;
        int idle;
        idle = 0;
        while (idle < QUIET_CYCLES)
        begin
            @(negedge clk);
            idle = mem_req ? 0 : idle + 1;
        end
    endtask

    ////////////////////////////////////////
    // one CPU request from start to finish
    task automatic apply_stim(input int idx);
        stim_t s;
        int    cycles;
        logic  saw_mem;
        word_t expected;
        s = stim[idx];
        while (cpu_stall)
            @(negedge clk);
        cpu_req_valid = 1'b1;
        cpu_req       = '{write: s.write, addr: s.addr, wdata: s.wdata};
        cycles        = 0;
        saw_mem       = 1'b0;
        do
        begin
            @(negedge clk);
            cycles++;
            cpu_req_valid = 1'b0;
            if (s.inject && cycles == 1)
            begin
                cpu_req_valid = 1'b1;  // lands in LOOKUP
                cpu_req       = '{write: 1'b1, addr: BOGUS_ADDR, wdata: BOGUS_DATA};
            end
            saw_mem |= mem_req;
            check_that(cpu_stall === 1'b1,
                $sformatf("entry %0d: cpu_stall low before cpu_done", idx));
        end
        while (cpu_done !== 1'b1);
        cpu_req_valid = 1'b0;

        expected = shadow[s.addr[15:1]];
        if (s.write)
            shadow[s.addr[15:1]] = s.wdata;
        else
            check_that(cpu_rdata === expected,
                $sformatf("entry %0d: read %h gave %h, expected %h",
                          idx, s.addr, cpu_rdata, expected));
        if (s.exp_hit)
        begin
            check_that(cycles == 2,
                $sformatf("entry %0d: hit took %0d cycles, expected 2", idx, cycles));
            check_that(!saw_mem, $sformatf("entry %0d: memory traffic on a hit", idx));
        end
        else
            check_that(saw_mem, $sformatf("entry %0d: miss without memory traffic", idx));

        wait_quiet();
        check_that(write_count == int'(s.exp_writes),
            $sformatf("entry %0d: %0d memory writes, expected %0d",
                      idx, write_count, s.exp_writes));
    endtask

    // checks the one dirty eviction byte by byte from the block base
    task automatic check_write_log;
        addr_t a;
        word_t w;
        byte_t expected;
        for (int i = 0; i < BYTES_PER_BLOCK; i++)
        begin
            a        = EVICT_BASE + addr_t'(i);
            w        = shadow[a[15:1]];
            expected = a[0] ? w[15:8] : w[7:0];
            check_that(u_mem.log_addr[i] === a,
                $sformatf("write %0d went to %h, expected %h", i, u_mem.log_addr[i], a));
            check_that(u_mem.log_data[i] === expected,
                $sformatf("write %0d to %h carried %h, expected %h",
                          i, a, u_mem.log_data[i], expected));
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    initial
    begin
        errors        = 0;
        checks        = 0;
        reset         = 1'b1;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        for (int i = 0; i < 32768; i++)
            shadow[i] = pattern_word(addr_t'(i << 1));
        load_stim();

        repeat (10)
            @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_that(cpu_stall === 1'b0 && mem_req === 1'b0,
            "cpu_stall or mem_req not low after reset");

        for (int i = 0; i < N_ENTRIES; i++)
            apply_stim(i);
        check_write_log();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    // watchdog sized from the table length
    initial
    begin
        #(N_ENTRIES * 2000);
        $display("timeout: the request table did not finish within %0d ns", N_ENTRIES * 2000);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/main_store_model.sv
// main store model
// byte-wide memory behind the cache. acks each transfer after a random
// delay of 1 to 4 cycles and keeps a log of every byte written
`timescale 1ns/10ps
`default_nettype none

module main_store_model
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      mem_req,
    input  wire cache_pkg::mem_req_t mem_cmd,
    output cache_pkg::byte_t         mem_rdata,
    output logic                     mem_ack,
    output int                       write_count
);
    import cache_pkg::*;

    localparam int LOG_DEPTH = 256;

    byte_t  mem      [0:65535];
    addr_t  log_addr [0:LOG_DEPTH-1];
    byte_t  log_data [0:LOG_DEPTH-1];
    integer seed;
    int     ack_delay;  // cycles left before the next ack

    // start pattern mixes both address bytes
    initial
    begin
        seed      = 66;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        for (int a = 0; a < 65536; a++)
            mem[a] = a[7:0] ^ a[15:8];
    end

    ////////////////////////////////////////
    // transfer handling on the falling edge
    always @(negedge clk or posedge reset)
    begin
        if (reset)
        begin
            mem_ack     <= 1'b0;
            mem_rdata   <= '0;
            write_count <= 0;
            ack_delay   <= 0;
        end
        else if (mem_ack)
            mem_ack <= 1'b0;  // one-cycle pulse before the next byte
        else if (mem_req)
        begin
            if (ack_delay == 0)
            begin
                mem_ack   <= 1'b1;
                ack_delay <= $unsigned($random(seed)) % 4;
                if (mem_cmd.write)
                begin
                    mem[mem_cmd.addr] = mem_cmd.wdata;
                    if (write_count < LOG_DEPTH)
                    begin
                        log_addr[write_count] = mem_cmd.addr;
                        log_data[write_count] = mem_cmd.wdata;
                    end
                    write_count <= write_count + 1;
                end
                else
                    mem_rdata <= mem[mem_cmd.addr];
            end
            else
                ack_delay <= ack_delay - 1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/cache_top.sv
// cache top level
// 4-way write-back, write-allocate cache in front of a byte-wide main store.
// the filler and the write-back FIFO share the one memory port
`timescale 1ns/10ps
`default_nettype none

module cache_top
(
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  cpu_req_valid,
    input  wire cache_pkg::cpu_req_t cpu_req,
    output logic                 cpu_stall,
    output logic                 cpu_done,
    output cache_pkg::word_t     cpu_rdata,
    output logic                 mem_req,
    output cache_pkg::mem_req_t  mem_cmd,
    input  wire cache_pkg::byte_t mem_rdata,
    input  wire                  mem_ack
);
    import cache_pkg::*;

    ////////////////////////////////////////
    // controller <-> store
    index_t    lk_index;
    tag_t      lk_tag;
    offset_t   lk_offset;
    logic      hit;
    way_t      hit_way;
    word_t     rdata;
    way_t      victim_way;
    victim_t   victim;
    logic      victim_valid;
    logic      victim_dirty;
    logic      upd_en;
    upd_kind_t upd_kind;
    way_t      upd_way;
    word_t     upd_word;
    block_t    upd_block;

    ////////////////////////////////////////
    // controller <-> filler, buffer
    logic      wbb_push;
    victim_t   wbb_victim;
    logic      wbb_full;
    logic      probe_hit;
    blk_addr_t probe_addr;
    logic      fill_start;
    blk_addr_t fill_addr;
    logic      fill_done;
    block_t    fill_block;

    // requesters <-> arbiter
    logic      fill_req, fill_grant, fill_ack;
    mem_req_t  fill_cmd;
    logic      wb_req, wb_grant, wb_ack;
    mem_req_t  wb_cmd;

    cache_controller u_ctrl
    (
        .clk, .reset, .cpu_req_valid, .cpu_req, .cpu_stall, .cpu_done, .cpu_rdata,
        .lk_index, .lk_tag, .lk_offset,
        .hit, .hit_way, .rdata, .victim_way, .victim, .victim_valid, .victim_dirty,
        .upd_en, .upd_kind, .upd_way, .upd_word, .upd_block,
        .wbb_push, .wbb_victim, .wbb_full, .probe_hit, .probe_addr,
        .fill_start, .fill_addr, .fill_done, .fill_block
    );

    cache_store u_store
    (
        .clk, .reset, .lk_index, .lk_tag, .lk_offset,
        .hit, .hit_way, .rdata, .victim_way, .victim, .victim_valid, .victim_dirty,
        .upd_en, .upd_kind, .upd_way, .upd_word, .upd_block
    );

    block_fill u_fill
    (
        .clk, .reset, .fill_start, .fill_addr, .fill_done, .fill_block,
        .req(fill_req), .cmd(fill_cmd), .grant(fill_grant), .ack(fill_ack),
        .rdata(mem_rdata)
    );

    write_back_buffer u_wbb
    (
        .clk, .reset, .push(wbb_push), .push_victim(wbb_victim), .full(wbb_full),
        .probe_addr, .probe_hit,
        .req(wb_req), .cmd(wb_cmd), .grant(wb_grant), .ack(wb_ack)
    );

    memory_arbiter u_arb
    (
        .clk, .reset,
        .fill_req, .fill_cmd, .fill_grant, .fill_ack,
        .wb_req, .wb_cmd, .wb_grant, .wb_ack,
        .mem_req, .mem_cmd, .mem_ack
    );

endmodule

`default_nettype wire

//--- verilog/memory_arbiter.sv
// memory arbiter
// shares the byte-wide memory port between the block filler and the
// write-back FIFO. fill wins a tie and a grant holds until its req drops
`timescale 1ns/10ps
`default_nettype none

module memory_arbiter
(
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       fill_req,
    input  wire cache_pkg::mem_req_t  fill_cmd,
    output logic                      fill_grant,
    output logic                      fill_ack,
    input  wire                       wb_req,
    input  wire cache_pkg::mem_req_t  wb_cmd,
    output logic                      wb_grant,
    output logic                      wb_ack,
    output logic                      mem_req,
    output cache_pkg::mem_req_t       mem_cmd,
    input  wire                       mem_ack
);
    typedef enum logic [1:0]
    {
        ARB_IDLE,
        ARB_FILL,
        ARB_WB
    } arb_state_e;

    arb_state_e state, next_state;

    always_comb
    begin
        next_state = state;
        case (state)
            ARB_FILL:
                if (!fill_req)
                    next_state = wb_req ? ARB_WB : ARB_IDLE;
            ARB_WB:
                if (!wb_req)
                    next_state = fill_req ? ARB_FILL : ARB_IDLE;
            default:
                if (fill_req)
                    next_state = ARB_FILL;
                else if (wb_req)
                    next_state = ARB_WB;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= ARB_IDLE;
        else
            state <= next_state;
    end

    assign fill_grant = (state == ARB_FILL);
    assign wb_grant   = (state == ARB_WB);

    assign mem_req  = (fill_grant && fill_req) || (wb_grant && wb_req);
    assign mem_cmd  = fill_grant ? fill_cmd : wb_cmd;
    assign fill_ack = mem_ack && fill_grant;  // ack only reaches the owner
    assign wb_ack   = mem_ack && wb_grant;

endmodule

`default_nettype wire

//--- verilog/write_back_buffer.sv
// write-back FIFO
// queues dirty victims and writes the oldest one back to memory
// one byte per transfer. the probe reports whether a block is still queued
`timescale 1ns/10ps
`default_nettype none

module write_back_buffer
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        push,
    input  wire cache_pkg::victim_t    push_victim,
    output logic                       full,
    input  wire cache_pkg::blk_addr_t  probe_addr,
    output logic                       probe_hit,
    output logic                       req,
    output cache_pkg::mem_req_t        cmd,
    input  wire                        grant,
    input  wire                        ack
);
    import cache_pkg::*;

    victim_t                      entries [WBB_DEPTH];
    wbb_ptr_t                     head, tail;
    logic [$clog2(WBB_DEPTH+1)-1:0] count;
    byte_cnt_t                    bcnt;     // byte within the draining block
    logic                         push_ok;
    logic                         pop;

    assign full    = (count == WBB_DEPTH);
    assign push_ok = push && !full;
    assign pop     = req && grant && ack && (bcnt == byte_cnt_t'(BYTES_PER_BLOCK - 1));

    assign cmd.write = 1'b1;
    assign cmd.addr  = {entries[tail].addr, bcnt};
    assign cmd.wdata = entries[tail].data[bcnt*8 +: 8];

    // occupied slots sit between tail and tail+count
    always_comb
    begin
        wbb_ptr_t rel;
        probe_hit = 1'b0;
        for (int i = 0; i < WBB_DEPTH; i++)
        begin
            rel = wbb_ptr_t'(i) - tail;
            if (rel < count && entries[i].addr == probe_addr)
                probe_hit = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            bcnt  <= '0;
            req   <= 1'b0;
        end
        else
        begin
            if (push_ok)
                head <= head + 1'b1;
            count <= count + push_ok - pop;

            if (!req && count != 0)
            begin
                req  <= 1'b1;  // start on the oldest entry
                bcnt <= '0;
            end
            else if (req && grant && ack)
            begin
                bcnt <= bcnt + 1'b1;
                if (pop)
                begin
                    req  <= 1'b0;
                    tail <= tail + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (push_ok)
            entries[head] <= push_victim;
    end

endmodule

`default_nettype wire

//--- verilog/block_fill.sv
// block filler
// reads the 16 bytes of one block from memory, lowest address first,
// and packs them into a block register for the controller
`timescale 1ns/10ps
`default_nettype none

module block_fill
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        fill_start,
    input  wire cache_pkg::blk_addr_t  fill_addr,
    output logic                       fill_done,
    output cache_pkg::block_t          fill_block,
    output logic                       req,
    output cache_pkg::mem_req_t        cmd,
    input  wire                        grant,
    input  wire                        ack,
    input  wire cache_pkg::byte_t      rdata
);
    import cache_pkg::*;

    blk_addr_t base_q;
    byte_cnt_t cnt;

    assign cmd.write = 1'b0;
    assign cmd.addr  = {base_q, cnt};
    assign cmd.wdata = '0;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            req       <= 1'b0;
            fill_done <= 1'b0;
            cnt       <= '0;
        end
        else
        begin
            fill_done <= 1'b0;
            if (fill_start)
            begin
                req <= 1'b1;
                cnt <= '0;
            end
            else if (req && grant && ack)
            begin
                cnt <= cnt + 1'b1;
                if (cnt == byte_cnt_t'(BYTES_PER_BLOCK - 1))
                begin
                    req       <= 1'b0; // last byte in
                    fill_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_start)
            base_q <= fill_addr;
        if (req && grant && ack)
            fill_block[cnt*8 +: 8] <= rdata;
    end

endmodule

`default_nettype wire

//--- verilog/cache_store.sv
// cache store
// tag, valid, dirty, age and data arrays for every set and way.
// lookup and victim choice are combinational and updates land on the clock
`timescale 1ns/10ps
`default_nettype none

module cache_store
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire cache_pkg::index_t     lk_index,
    input  wire cache_pkg::tag_t       lk_tag,
    input  wire cache_pkg::offset_t    lk_offset,
    output logic                       hit,
    output cache_pkg::way_t            hit_way,
    output cache_pkg::word_t           rdata,
    output cache_pkg::way_t            victim_way,
    output cache_pkg::victim_t         victim,
    output logic                       victim_valid,
    output logic                       victim_dirty,
    input  wire                        upd_en,
    input  wire cache_pkg::upd_kind_t  upd_kind,
    input  wire cache_pkg::way_t       upd_way,
    input  wire cache_pkg::word_t      upd_word,
    input  wire cache_pkg::block_t     upd_block
);
    import cache_pkg::*;

    tag_t                 tag_mem   [NUM_SETS][NUM_WAYS];
    block_t               data_mem  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0]  valid_mem [NUM_SETS];
    logic [NUM_WAYS-1:0]  dirty_mem [NUM_SETS];
    age_t                 age_mem   [NUM_SETS][NUM_WAYS];

    ////////////////////////////////////////
    // lookup
    always_comb
    begin
        hit        = 1'b0;
        hit_way    = '0;
        victim_way = '0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (valid_mem[lk_index][w] && tag_mem[lk_index][w] == lk_tag)
            begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
            if (age_mem[lk_index][w] == age_t'(NUM_WAYS - 1))
                victim_way = way_t'(w);  // oldest way
        end
        // the lowest-numbered empty way beats the oldest
        for (int w = NUM_WAYS - 1; w >= 0; w--)
            if (!valid_mem[lk_index][w])
                victim_way = way_t'(w);
    end

    assign rdata = data_mem[lk_index][hit_way][lk_offset*WORD_W +: WORD_W];

    assign victim.addr  = {tag_mem[lk_index][victim_way], lk_index};
    assign victim.data  = data_mem[lk_index][victim_way];
    assign victim_valid = valid_mem[lk_index][victim_way];
    assign victim_dirty = dirty_mem[lk_index][victim_way];

    ////////////////////////////////////////
    // updates
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int s = 0; s < NUM_SETS; s++)
            begin
                valid_mem[s] <= '0;
                dirty_mem[s] <= '0;
                for (int w = 0; w < NUM_WAYS; w++)
                    age_mem[s][w] <= age_t'(w); // distinct ages from the start
            end
        end
        else if (upd_en)
        begin
            if (upd_kind == UPD_INSTALL)
            begin
                valid_mem[lk_index][upd_way] <= 1'b1;
                dirty_mem[lk_index][upd_way] <= 1'b0;
            end
            else if (upd_kind == UPD_WORD)
                dirty_mem[lk_index][upd_way] <= 1'b1;

            for (int w = 0; w < NUM_WAYS; w++)
            begin
                if (way_t'(w) == upd_way)
                    age_mem[lk_index][w] <= '0;
                else if (age_mem[lk_index][w] < age_mem[lk_index][upd_way])
                    age_mem[lk_index][w] <= age_mem[lk_index][w] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (upd_en && upd_kind == UPD_INSTALL)
        begin
            tag_mem[lk_index][upd_way]  <= lk_tag;
            data_mem[lk_index][upd_way] <= upd_block;
        end
        else if (upd_en && upd_kind == UPD_WORD)
            data_mem[lk_index][upd_way][lk_offset*WORD_W +: WORD_W] <= upd_word;
    end

endmodule

`default_nettype wire

//--- verilog/cache_controller.sv
// cache controller
// takes one CPU request at a time and sequences lookup, victim push,
// block fill, install and the final word access
`timescale 1ns/10ps
`default_nettype none

module cache_controller
(
    input  wire                       clk,
    input  wire                       reset,
    // cpu side
    input  wire                       cpu_req_valid,
    input  wire cache_pkg::cpu_req_t  cpu_req,
    output logic                      cpu_stall,
    output logic                      cpu_done,
    output cache_pkg::word_t          cpu_rdata,
    // store lookup
    output cache_pkg::index_t         lk_index,
    output cache_pkg::tag_t           lk_tag,
    output cache_pkg::offset_t        lk_offset,
    input  wire                       hit,
    input  wire cache_pkg::way_t      hit_way,
    input  wire cache_pkg::word_t     rdata,
    input  wire cache_pkg::way_t      victim_way,
    input  wire cache_pkg::victim_t   victim,
    input  wire                       victim_valid,
    input  wire                       victim_dirty,
    // store update
    output logic                      upd_en,
    output cache_pkg::upd_kind_t      upd_kind,
    output cache_pkg::way_t           upd_way,
    output cache_pkg::word_t          upd_word,
    output cache_pkg::block_t         upd_block,
    // write-back FIFO
    output logic                      wbb_push,
    output cache_pkg::victim_t        wbb_victim,
    input  wire                       wbb_full,
    input  wire                       probe_hit,
    output cache_pkg::blk_addr_t      probe_addr,
    // block filler
    output logic                      fill_start,
    output cache_pkg::blk_addr_t      fill_addr,
    input  wire                       fill_done,
    input  wire cache_pkg::block_t    fill_block
);
    import cache_pkg::*;

    typedef enum logic [2:0]
    {
        IDLE,
        LOOKUP,
        EVICT,
        FILL_WAIT,
        INSTALL,
        ACCESS
    } ctrl_state_e;

    ctrl_state_e state;
    cpu_req_t    req_q;     // accepted request
    way_t        way_q;     // hit way or chosen victim
    logic        fill_busy; // fill launched, waiting for done
    logic        must_push;

    assign lk_tag     = req_q.addr[15:12];
    assign lk_index   = req_q.addr[11:4];
    assign lk_offset  = req_q.addr[3:1];
    assign probe_addr = req_q.addr[15:4];
    assign fill_addr  = req_q.addr[15:4];

    assign must_push = victim_valid && victim_dirty;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state     <= IDLE;
            fill_busy <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (cpu_req_valid)
                        state <= LOOKUP;
                LOOKUP:
                    state <= hit ? ACCESS : EVICT;
                EVICT:
                    if (!must_push || !wbb_full)  // hold while FIFO is full
                        state <= FILL_WAIT;
                FILL_WAIT:
                begin
                    if (fill_start)
                        fill_busy <= 1'b1;
                    if (fill_done)
                    begin
                        fill_busy <= 1'b0;
                        state     <= INSTALL;
                    end
                end
                INSTALL:
                    state <= ACCESS;
                default:
                    state <= IDLE; // ACCESS finishes the request
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == IDLE && cpu_req_valid)
            req_q <= cpu_req;
        if (state == LOOKUP)
            way_q <= hit ? hit_way : victim_way;
    end

    assign cpu_stall = (state != IDLE);
    assign cpu_done  = (state == ACCESS);
    assign cpu_rdata = rdata;  // store output for the current request

    assign wbb_push   = (state == EVICT) && must_push && !wbb_full;
    assign wbb_victim = victim;

    // a queued copy of the block must reach memory before refetching it
    assign fill_start = (state == FILL_WAIT) && !fill_busy && !probe_hit;

    ////////////////////////////////////////
    // store updates
    assign upd_en    = (state == INSTALL) || (state == ACCESS);
    assign upd_kind  = (state == INSTALL) ? UPD_INSTALL :
                       req_q.write        ? UPD_WORD    : UPD_TOUCH;
    assign upd_way   = way_q;
    assign upd_word  = req_q.wdata;
    assign upd_block = fill_block;

endmodule

`default_nettype wire

//--- verilog/cache_pkg.sv
// cache package
// widths, typedefs and bus structs shared by the 4-way write-back cache,
// its block filler, write-back FIFO and memory arbiter
`default_nettype none

package cache_pkg;

    localparam int ADDR_W          = 16;
    localparam int WORD_W          = 16;
    localparam int WORDS_PER_BLOCK = 8;
    localparam int BYTES_PER_BLOCK = 16;
    localparam int TAG_W           = 4;
    localparam int INDEX_W         = 8;
    localparam int NUM_WAYS        = 4;
    localparam int WBB_DEPTH       = 4;
    localparam int NUM_SETS        = 1 << INDEX_W;

    typedef logic [ADDR_W-1:0]                 addr_t;
    typedef logic [WORD_W-1:0]                 word_t;
    typedef logic [7:0]                        byte_t;
    typedef logic [WORDS_PER_BLOCK*WORD_W-1:0] block_t;  // word 0 in low bits
    typedef logic [TAG_W-1:0]                  tag_t;    // addr[15:12]
    typedef logic [INDEX_W-1:0]                index_t;  // addr[11:4]
    typedef logic [2:0]                        offset_t; // addr[3:1]
    typedef logic [TAG_W+INDEX_W-1:0]          blk_addr_t;
    typedef logic [$clog2(NUM_WAYS)-1:0]       way_t;
    typedef logic [$clog2(NUM_WAYS)-1:0]       age_t;    // 0 is most recent
    typedef logic [$clog2(BYTES_PER_BLOCK)-1:0] byte_cnt_t;
    typedef logic [$clog2(WBB_DEPTH)-1:0]      wbb_ptr_t;

    // store update kinds
    typedef logic [1:0] upd_kind_t;
    localparam upd_kind_t UPD_WORD    = 2'd0;
    localparam upd_kind_t UPD_INSTALL = 2'd1;
    localparam upd_kind_t UPD_TOUCH   = 2'd2; // lru only

    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  write;
        addr_t addr;
        byte_t wdata;
    } mem_req_t;

    typedef struct packed {
        blk_addr_t addr;
        block_t    data;
    } victim_t;

endpackage

`default_nettype wire
